/* bench/mem_complex_cases.txt */
// Columns: write flag, word address, write data, expected response data
// One case per line, the line number is the command tag
0_0000_00000000_a5a50000
0_0001_00000000_a5a50001
0_0002_00000000_a5a50002
0_0003_00000000_a5a50003
0_0000_00000000_a5a50000 // hit
0_0001_00000000_a5a50001 // hit
1_0002_12345678_12345678 // write hit
0_0002_00000000_12345678
1_0007_deadbeef_deadbeef // write miss, no allocate
0_0007_00000000_deadbeef
0_0021_00000000_a5a50021 // same set as 0001
0_0001_00000000_a5a50001
0_0102_00000000_a5a50102 // same set as 0002
0_0002_00000000_12345678
1_0004_cafef00d_cafef00d
0_0004_00000000_cafef00d
0_0fff_00000000_a5a50fff
0_0fff_00000000_a5a50fff

/* mem_complex.f */
hdl/mem_cfg_pkg.sv
hdl/mem_noc_pkg.sv
hdl/mem_cmd_hop.sv
hdl/mem_resp_hop.sv
hdl/mem_cache.sv
hdl/mem_node.sv
hdl/mem_complex.sv
bench/mem_complex_assert.sv
bench/mem_complex_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = mem_complex_tb
FILELIST  = mem_complex.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/mem_complex_tb.sv */
`timescale 1ns/1ns

module mem_complex_tb
  import mem_cfg_pkg::*;
  import mem_noc_pkg::*;
  ();

  localparam int num_mem_lp   = NUM_MEM_DEF;
  localparam int sets_lp      = SETS_DEF;
  localparam int num_cases_lp = 18;
  localparam int limit_lp     = num_cases_lp * 60 + 8;  // Cycles, reset included

  typedef struct packed {
    logic [3:0] wr;
    addr_t      addr;
    data_t      data;
    data_t      resp_data;  // Expected response data
  } case_s;

  logic                      core_clk_i;
  logic                      rst_n_i;
  mem_cmd_s                  cmd_i;
  logic                      cmd_v_i;
  mem_resp_s                 resp_o;
  logic                      resp_v_o;
  dma_pkt_s [num_mem_lp-1:0] dma_pkt_o;
  logic [num_mem_lp-1:0]     dma_pkt_v_o;
  data_t [num_mem_lp-1:0]    dma_data_i;
  logic [num_mem_lp-1:0]     dma_data_v_i;

  logic [83:0] cases_mem [num_cases_lp];
  data_t       mem_model [65536];
  logic [7:0]  lfsr_r;
  int          rd_wait [num_mem_lp];
  addr_t       rd_addr [num_mem_lp];
  logic        ref_v   [num_mem_lp][sets_lp];  // Expected cache contents
  int          ref_tag [num_mem_lp][sets_lp];

  int          issued_cnt   [num_mem_lp];
  int          returned_cnt [num_mem_lp];
  int          dma_want_cnt [num_mem_lp];
  int          dma_seen_cnt [num_mem_lp];
  dma_pkt_s    dma_exp      [num_mem_lp];
  logic        sent         [num_cases_lp];
  logic        got          [num_cases_lp];
  data_t       exp_data     [num_cases_lp];
  int          tag_col      [num_cases_lp];
  int          done_cnt;

  mem_complex #(.num_mem_p(num_mem_lp), .sets_p(sets_lp)) i_dut
  (.core_clk_i   (core_clk_i)
  , .rst_n_i      (rst_n_i)
  , .cmd_i        (cmd_i)
  , .cmd_v_i      (cmd_v_i)
  , .resp_o       (resp_o)
  , .resp_v_o     (resp_v_o)
  , .dma_pkt_o    (dma_pkt_o)
  , .dma_pkt_v_o  (dma_pkt_v_o)
  , .dma_data_i   (dma_data_i)
  , .dma_data_v_i (dma_data_v_i)
  );

  initial
  begin
    core_clk_i = 1'b0;
    forever #20 core_clk_i = ~core_clk_i;
  end

  task automatic abort_run(input string why);
    if (why != "")
      $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [63:0] got_v,
                               input logic [63:0] exp_v);
    if (got_v !== exp_v)
    begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got_v, exp_v);
      abort_run("");
    end
  endtask

  // Galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
  endfunction

  // ################################################
  // Case issue
  // ################################################

  initial
  begin : issue
    case_s tc;
    int    i;
    int    col;
    int    set;
    int    ltag;
    logic  need_dma;

    rst_n_i = 1'b0;
    cmd_i   = '0;
    cmd_v_i = 1'b0;
    for (int c = 0; c < num_mem_lp; c++)
    begin
      issued_cnt[c]   = 0;
      dma_want_cnt[c] = 0;
      for (int s = 0; s < sets_lp; s++)
        ref_v[c][s] = 1'b0;
    end
    for (int t = 0; t < num_cases_lp; t++)
      sent[t] = 1'b0;
    $readmemh("bench/mem_complex_cases.txt", cases_mem);

    repeat (4) @(posedge core_clk_i);
    rst_n_i <= 1'b1;

    i = 0;
    while (i < num_cases_lp)
    begin
      @(posedge core_clk_i);
      tc  = case_s'(cases_mem[i]);
      col = int'(tc.addr) % num_mem_lp;
      if (issued_cnt[col] != returned_cnt[col])
        cmd_v_i <= 1'b0;  // Home node busy
      else
      begin
        set      = (int'(tc.addr) / num_mem_lp) % sets_lp;
        ltag     = int'(tc.addr) / (num_mem_lp * sets_lp);
        need_dma = tc.wr[0] || !(ref_v[col][set] && ref_tag[col][set] == ltag);
        if (!tc.wr[0])
        begin
          ref_v[col][set]   = 1'b1;  // Reads allocate, writes never do
          ref_tag[col][set] = ltag;
        end
        cmd_i   <= '{tag: tag_t'(i), wr: tc.wr[0], dest: 4'hf, addr: tc.addr, data: tc.data};
        cmd_v_i <= 1'b1;
        if (need_dma)
        begin
          dma_exp[col]      <= '{wr: tc.wr[0], addr: tc.addr, data: tc.data};
          dma_want_cnt[col] <= dma_want_cnt[col] + 1;
        end
        issued_cnt[col] <= issued_cnt[col] + 1;
        sent[i]         <= 1'b1;
        exp_data[i]     <= tc.resp_data;
        tag_col[i]      <= col;
        i++;
      end
    end
    @(posedge core_clk_i);
    cmd_v_i <= 1'b0;

    while (done_cnt != num_cases_lp)
      @(posedge core_clk_i);
    repeat (2) @(posedge core_clk_i);

    if (i_dut.i_assert.fail_cnt == 0)
    begin
      $display("Test passed");
      $finish;
    end
    else
      abort_run("Protocol assertions fired during the run");
  end

  // ################################################
  // Scoreboard on the response port
  // ################################################

  initial
  begin : monitor
    int t;
    int c;

    done_cnt = 0;
    for (int k = 0; k < num_mem_lp; k++)
      returned_cnt[k] = 0;
    for (int k = 0; k < num_cases_lp; k++)
      got[k] = 1'b0;
    forever
    begin
      @(posedge core_clk_i);
      if (resp_v_o === 1'b1)
      begin
        t = int'(resp_o.tag);
        if (t >= num_cases_lp || !sent[t] || got[t])
          abort_run("Response carries a tag that is not outstanding");
        c = tag_col[t];
        compare_value("resp_o.data", 64'(resp_o.data), 64'(exp_data[t]));
        if (dma_want_cnt[c] != dma_seen_cnt[c])
          abort_run("Response came back without its DMA packet");
        got[t]          <= 1'b1;
        returned_cnt[c] <= returned_cnt[c] + 1;
        done_cnt        <= done_cnt + 1;
      end
    end
  end

  // ################################################
  // DMA memory model
  // ################################################

  initial
  begin : dma_model
    dma_data_i   = '0;
    dma_data_v_i = '0;
    lfsr_r       = 8'd82;
    for (int a = 0; a < 65536; a++)
      mem_model[a] = data_t'(a) ^ 32'ha5a5_0000;
    for (int c = 0; c < num_mem_lp; c++)
    begin
      rd_wait[c]      = 0;
      dma_seen_cnt[c] = 0;
    end
    forever
    begin
      @(posedge core_clk_i);
      for (int c = 0; c < num_mem_lp; c++)
      begin
        dma_data_v_i[c] <= 1'b0;
        if (rd_wait[c] == 1)
        begin
          dma_data_i[c]   <= mem_model[rd_addr[c]];
          dma_data_v_i[c] <= 1'b1;
        end
        if (rd_wait[c] > 0)
          rd_wait[c] = rd_wait[c] - 1;
        if (dma_pkt_v_o[c] === 1'b1)
        begin
          if (dma_want_cnt[c] == dma_seen_cnt[c])
            abort_run("DMA packet from a column that should stay quiet");
          compare_value("dma_pkt_o.wr", 64'(dma_pkt_o[c].wr), 64'(dma_exp[c].wr));
          compare_value("dma_pkt_o.addr", 64'(dma_pkt_o[c].addr), 64'(dma_exp[c].addr));
          if (dma_exp[c].wr)
          begin
            compare_value("dma_pkt_o.data", 64'(dma_pkt_o[c].data), 64'(dma_exp[c].data));
            mem_model[dma_pkt_o[c].addr] = dma_pkt_o[c].data;
          end
          else
          begin
            rd_addr[c] = dma_pkt_o[c].addr;
            rd_wait[c] = 1;
            for (int b = 0; b < 2; b++)  // 1 to 4 cycles
            begin
              rd_wait[c] = rd_wait[c] + (int'(lfsr_r[0]) << b);
              lfsr_r     = lfsr_step(lfsr_r);
            end
          end
          dma_seen_cnt[c] <= dma_seen_cnt[c] + 1;
        end
      end
    end
  end

  initial
  begin : watchdog
    repeat (limit_lp) @(posedge core_clk_i);
    abort_run("Timeout: responses still missing after the cycle budget");
  end

endmodule

/* bench/mem_complex_assert.sv */
`timescale 1ns/1ns

module mem_complex_assert
  import mem_cfg_pkg::*;
  import mem_noc_pkg::*;
  #(parameter int num_mem_p = NUM_MEM_DEF
  )
  (input  logic                     core_clk_i
  , input  logic                     rst_n_i
  , input  mem_cmd_s                 cmd_i
  , input  logic                     cmd_v_i
  , input  mem_resp_s                resp_i
  , input  logic                     resp_v_i
  , input  dma_pkt_s [num_mem_p-1:0] dma_pkt_i
  , input  logic [num_mem_p-1:0]     dma_pkt_v_i
  , input  logic [num_mem_p-1:0]     dma_data_v_i
  );

  logic [num_mem_p-1:0] busy_r;       // Command in flight per home column
  tag_t                 busy_tag_r [num_mem_p];
  logic [num_mem_p-1:0] miss_pend_r;  // DMA read out, data not back yet
  int                   home;
  int                   fail_cnt = 0;

  always_comb
    home = int'(cmd_i.addr) % num_mem_p;

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      busy_r      <= '0;
      miss_pend_r <= '0;
    end
    else
    begin
      for (int c = 0; c < num_mem_p; c++)
      begin
        if (resp_v_i && busy_r[c] && resp_i.tag == busy_tag_r[c])
          busy_r[c] <= 1'b0;
        if (cmd_v_i && home == c)
        begin
          busy_r[c]     <= 1'b1;
          busy_tag_r[c] <= cmd_i.tag;
        end
        if (dma_pkt_v_i[c] && !dma_pkt_i[c].wr)
          miss_pend_r[c] <= 1'b1;
        else if (dma_data_v_i[c])
          miss_pend_r[c] <= 1'b0;
      end
    end
  end

  // ################################################
  // Port protocol
  // ################################################

  a_quiet_in_reset: assert property (@(posedge core_clk_i)
    !rst_n_i |=> !resp_v_i && !(|dma_pkt_v_i))
  else
  begin
    fail_cnt++;
    $error("response or DMA strobe while in reset");
  end

  a_data_on_miss: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    (dma_data_v_i & ~miss_pend_r) == '0)
  else
  begin
    fail_cnt++;
    $error("DMA data for a node that is not waiting on a miss");
  end

  a_one_outstanding: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    cmd_v_i |-> !busy_r[home])
  else
  begin
    fail_cnt++;
    $error("command sent to a node that is still busy");
  end

endmodule

bind mem_complex mem_complex_assert #(.num_mem_p(num_mem_p)) i_assert
(.core_clk_i   (core_clk_i)
, .rst_n_i      (rst_n_i)
, .cmd_i        (cmd_i)
, .cmd_v_i      (cmd_v_i)
, .resp_i       (resp_o)
, .resp_v_i     (resp_v_o)
, .dma_pkt_i    (dma_pkt_o)
, .dma_pkt_v_i  (dma_pkt_v_o)
, .dma_data_v_i (dma_data_v_i)
);

/* hdl/mem_complex.sv */
`timescale 1ns/1ns

module mem_complex
  import mem_cfg_pkg::*;
  import mem_noc_pkg::*;
  #(parameter int num_mem_p = NUM_MEM_DEF
  , parameter int sets_p    = SETS_DEF
  )
  (input  logic                      core_clk_i
  , input  logic                      rst_n_i
  , input  mem_cmd_s                  cmd_i    // dest is ignored here
  , input  logic                      cmd_v_i
  , output mem_resp_s                 resp_o
  , output logic                      resp_v_o
  , output dma_pkt_s [num_mem_p-1:0]  dma_pkt_o
  , output logic [num_mem_p-1:0]      dma_pkt_v_o
  , input  data_t [num_mem_p-1:0]     dma_data_i
  , input  logic [num_mem_p-1:0]      dma_data_v_i
  );

  // Element i feeds node i; the last command element is the open east end
  mem_cmd_s  cmd_w    [num_mem_p+1];
  logic      cmd_v_w  [num_mem_p+1];
  mem_resp_s resp_w   [num_mem_p+1];
  logic      resp_v_w [num_mem_p+1];
  mem_cmd_s  cmd_head;

  // Home column from the low address bits
  always_comb
  begin
    cmd_head      = cmd_i;
    cmd_head.dest = col_t'(cmd_i.addr % addr_t'(num_mem_p));
  end

  assign cmd_w[0]   = cmd_head;
  assign cmd_v_w[0] = cmd_v_i;

  assign resp_w[num_mem_p]   = '0;  // East end of the response row is idle
  assign resp_v_w[num_mem_p] = 1'b0;

  // ################################################
  // Row of nodes
  // ################################################

  for (genvar i = 0; i < num_mem_p; i++)
  begin : g_node
    mem_node #(.num_mem_p(num_mem_p), .sets_p(sets_p), .my_col_p(i)) i_node
    (.core_clk_i   (core_clk_i)
    , .rst_n_i      (rst_n_i)
    , .cmd_i        (cmd_w[i])
    , .cmd_v_i      (cmd_v_w[i])
    , .cmd_o        (cmd_w[i+1])
    , .cmd_v_o      (cmd_v_w[i+1])
    , .pass_i       (resp_w[i+1])
    , .pass_v_i     (resp_v_w[i+1])
    , .resp_o       (resp_w[i])
    , .resp_v_o     (resp_v_w[i])
    , .dma_pkt_o    (dma_pkt_o[i])
    , .dma_pkt_v_o  (dma_pkt_v_o[i])
    , .dma_data_i   (dma_data_i[i])
    , .dma_data_v_i (dma_data_v_i[i])
    );
  end

  assign resp_o   = resp_w[0];
  assign resp_v_o = resp_v_w[0];

endmodule

/* hdl/mem_node.sv */
`timescale 1ns/1ns

module mem_node
  import mem_cfg_pkg::*;
  import mem_noc_pkg::*;
  #(parameter int num_mem_p = NUM_MEM_DEF
  , parameter int sets_p    = SETS_DEF
  , parameter int my_col_p  = 0
  )
  (input  logic      core_clk_i
  , input  logic      rst_n_i
  , input  mem_cmd_s  cmd_i
  , input  logic      cmd_v_i
  , output mem_cmd_s  cmd_o
  , output logic      cmd_v_o
  , input  mem_resp_s pass_i
  , input  logic      pass_v_i
  , output mem_resp_s resp_o
  , output logic      resp_v_o
  , output dma_pkt_s  dma_pkt_o
  , output logic      dma_pkt_v_o
  , input  data_t     dma_data_i
  , input  logic      dma_data_v_i
  );

  mem_cmd_s  local_cmd;
  logic      local_cmd_v;
  mem_resp_s local_resp;
  logic      local_resp_v;

  mem_cmd_hop #(.my_col_p(my_col_p)) i_cmd_hop
  (.core_clk_i  (core_clk_i)
  , .rst_n_i     (rst_n_i)
  , .cmd_i       (cmd_i)
  , .cmd_v_i     (cmd_v_i)
  , .cmd_o       (cmd_o)
  , .cmd_v_o     (cmd_v_o)
  , .local_cmd_o (local_cmd)
  , .local_v_o   (local_cmd_v)
  );

  mem_cache #(.num_mem_p(num_mem_p), .sets_p(sets_p)) i_cache
  (.core_clk_i   (core_clk_i)
  , .rst_n_i      (rst_n_i)
  , .cmd_i        (local_cmd)
  , .cmd_v_i      (local_cmd_v)
  , .resp_o       (local_resp)
  , .resp_v_o     (local_resp_v)
  , .dma_pkt_o    (dma_pkt_o)
  , .dma_pkt_v_o  (dma_pkt_v_o)
  , .dma_data_i   (dma_data_i)
  , .dma_data_v_i (dma_data_v_i)
  );

  mem_resp_hop i_resp_hop
  (.core_clk_i (core_clk_i)
  , .rst_n_i    (rst_n_i)
  , .pass_i     (pass_i)
  , .pass_v_i   (pass_v_i)
  , .local_i    (local_resp)
  , .local_v_i  (local_resp_v)
  , .resp_o     (resp_o)
  , .resp_v_o   (resp_v_o)
  );

endmodule

/* hdl/mem_cache.sv */
`timescale 1ns/1ns

module mem_cache
  import mem_cfg_pkg::*;
  import mem_noc_pkg::*;
  #(parameter int num_mem_p = NUM_MEM_DEF
  , parameter int sets_p    = SETS_DEF
  )
  (input  logic      core_clk_i
  , input  logic      rst_n_i
  , input  mem_cmd_s  cmd_i
  , input  logic      cmd_v_i
  , output mem_resp_s resp_o
  , output logic      resp_v_o
  , output dma_pkt_s  dma_pkt_o
  , output logic      dma_pkt_v_o
  , input  data_t     dma_data_i
  , input  logic      dma_data_v_i
  );

  // Address split: | line tag | index | column |
  localparam int col_w_lp  = $clog2(num_mem_p);
  localparam int idx_w_lp  = $clog2(sets_p);
  localparam int ltag_w_lp = $bits(addr_t) - col_w_lp - idx_w_lp;

  typedef logic [idx_w_lp-1:0]  idx_t;
  typedef logic [ltag_w_lp-1:0] ltag_t;

  typedef enum logic [1:0] {
    e_idle,
    e_miss_wait,
    e_respond
  } state_e;

  state_e            state_r;
  logic [sets_p-1:0] val_r;
  ltag_t             ltag_r [sets_p];
  data_t             data_r [sets_p];

  mem_cmd_s          cmd_r;    // Command being served
  data_t             rdata_r;  // Response data
  logic              dma_v_r;

  idx_t              idx_in;
  ltag_t             ltag_in;
  idx_t              idx_pend;
  ltag_t             ltag_pend;
  logic              hit;
  logic              accept;
  logic              fill;

  assign idx_in    = cmd_i.addr[col_w_lp +: idx_w_lp];
  assign ltag_in   = cmd_i.addr[col_w_lp + idx_w_lp +: ltag_w_lp];
  assign idx_pend  = cmd_r.addr[col_w_lp +: idx_w_lp];
  assign ltag_pend = cmd_r.addr[col_w_lp + idx_w_lp +: ltag_w_lp];

  assign hit    = val_r[idx_in] && (ltag_r[idx_in] == ltag_in);
  assign accept = (state_r == e_idle) & cmd_v_i;
  assign fill   = (state_r == e_miss_wait) & dma_data_v_i;

  // ################################################
  // Controller
  // ################################################

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= e_idle;
      dma_v_r <= 1'b0;
      val_r   <= '0;
    end
    else
    begin
      dma_v_r <= 1'b0;
      case (state_r)
        e_idle:
          if (cmd_v_i)
          begin
            dma_v_r <= cmd_i.wr | ~hit;  // Write-through, or read miss
            state_r <= (cmd_i.wr | hit) ? e_respond : e_miss_wait;
          end
        e_miss_wait:
          if (dma_data_v_i)
          begin
            val_r[idx_pend] <= 1'b1;
            state_r         <= e_respond;
          end
        default:
          state_r <= e_idle;
      endcase
    end
  end

  // Line storage and response data
  always_ff @(posedge core_clk_i)
  begin
    if (accept)
    begin
      cmd_r   <= cmd_i;
      rdata_r <= cmd_i.wr ? cmd_i.data : data_r[idx_in];
      if (cmd_i.wr && hit)
        data_r[idx_in] <= cmd_i.data;  // No allocate on a write miss
    end
    if (fill)
    begin
      rdata_r          <= dma_data_i;
      data_r[idx_pend] <= dma_data_i;
      ltag_r[idx_pend] <= ltag_pend;
    end
  end

  assign resp_o      = '{tag: cmd_r.tag, data: rdata_r};
  assign resp_v_o    = (state_r == e_respond);
  assign dma_pkt_o   = '{wr: cmd_r.wr, addr: cmd_r.addr, data: cmd_r.data};
  assign dma_pkt_v_o = dma_v_r;

endmodule

/* hdl/mem_resp_hop.sv */
`timescale 1ns/1ns

module mem_resp_hop
  import mem_noc_pkg::*;
  (input  logic      core_clk_i
  , input  logic      rst_n_i
  , input  mem_resp_s pass_i   // From the east neighbour
  , input  logic      pass_v_i
  , input  mem_resp_s local_i  // From the own cache
  , input  logic      local_v_i
  , output mem_resp_s resp_o   // Westward
  , output logic      resp_v_o
  );

  mem_resp_s [1:0] q_r;        // Local queue, entry 0 is the head
  logic [1:0]      cnt_r;
  logic [1:0]      cnt_after_pop;
  mem_resp_s       resp_r;
  logic            resp_v_r;
  logic            pop;
  logic            bypass;
  logic            push;

  // ################################################
  // Output arbitration, passing traffic first
  // ################################################

  assign pop    = ~pass_v_i & (cnt_r != 2'd0);
  assign bypass = ~pass_v_i & (cnt_r == 2'd0) & local_v_i;  // Empty queue, idle output
  assign push   = local_v_i & ~bypass;

  assign cnt_after_pop = cnt_r - {1'b0, pop};

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_r <= 1'b0;
      cnt_r    <= 2'd0;
    end
    else
    begin
      resp_v_r <= pass_v_i | pop | bypass;
      cnt_r    <= cnt_after_pop + {1'b0, push};
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (pass_v_i)
      resp_r <= pass_i;
    else if (pop)
      resp_r <= q_r[0];
    else if (bypass)
      resp_r <= local_i;

    if (pop)
      q_r[0] <= q_r[1];
    if (push)
      q_r[cnt_after_pop[0]] <= local_i;  // Overrides the shift when it lands on the head
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

endmodule

/* hdl/mem_cmd_hop.sv */
`timescale 1ns/1ns

module mem_cmd_hop
  import mem_cfg_pkg::*;
  import mem_noc_pkg::*;
  #(parameter int my_col_p = 0
  )
  (input  logic     core_clk_i
  , input  logic     rst_n_i
  , input  mem_cmd_s cmd_i
  , input  logic     cmd_v_i
  , output mem_cmd_s cmd_o        // East neighbour
  , output logic     cmd_v_o
  , output mem_cmd_s local_cmd_o  // Own cache
  , output logic     local_v_o
  );

  mem_cmd_s flit_r;
  logic     v_r;
  logic     mine;

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
      v_r <= 1'b0;
    else
      v_r <= cmd_v_i;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (cmd_v_i)
      flit_r <= cmd_i;
  end

  // Steer the registered flit
  assign mine = (flit_r.dest == col_t'(my_col_p));

  assign local_cmd_o = flit_r;
  assign local_v_o   = v_r & mine;
  assign cmd_o       = flit_r;
  assign cmd_v_o     = v_r & ~mine;

endmodule

/* hdl/mem_noc_pkg.sv */
package mem_noc_pkg;

  import mem_cfg_pkg::*;

  // Command flit, travels east on the command row
  typedef struct packed {
    tag_t  tag;
    logic  wr;    // 1 = write, 0 = read
    col_t  dest;  // Home column, filled in at the entry point
    addr_t addr;
    data_t data;
  } mem_cmd_s;

  // Response flit, travels west on the response row
  typedef struct packed {
    tag_t  tag;
    data_t data;  // Read data or echoed write data
  } mem_resp_s;

  // DMA request to the backing memory
  typedef struct packed {
    logic  wr;
    addr_t addr;
    data_t data;  // Only meaningful for writes
  } dma_pkt_s;

endpackage

/* hdl/mem_cfg_pkg.sv */
package mem_cfg_pkg;

  // ################################################
  // Widths with a meaning of their own
  // ################################################

  typedef logic [15:0] addr_t;  // Word address
  typedef logic [31:0] data_t;  // Data word
  typedef logic [7:0]  tag_t;   // Command tag, returned with the response
  typedef logic [3:0]  col_t;   // Column index, up to 16 nodes

  // ################################################
  // Default sizes
  // ################################################

  // Node count, keep a power of two so the home column is the low address bits
  localparam int NUM_MEM_DEF = 4;

  localparam int SETS_DEF    = 8;  // Sets per node cache

endpackage
